// File: hdl/ldpc_defines.svh
// ------------------------------------------------
// global sizes for the ldpc row-update datapath.
// include this header in any file that needs widths,
// the normalisation factor or the buffer depths.
// ------------------------------------------------

`ifndef LDPC_DEFINES_SVH
`define LDPC_DEFINES_SVH

// check-node message width in bits, sign included.
`define LDPC_NODE_W       8

// accumulated variable-node sum carries two guard bits.
`define LDPC_SUM_W        (`LDPC_NODE_W + 2)

// normalisation numerator over 8, so 6 gives 0.75.
`define LDPC_NORM_FACTOR  6

// widest parity-check row handled by one pass.
`define LDPC_ROW_DEG_MAX  16

// column address width of a variable node.
`define LDPC_COL_W        16

// the beat buffer holds up to two full rows in flight.
`define LDPC_BEAT_DEPTH   (2 * `LDPC_ROW_DEG_MAX)
`define LDPC_ROW_DEPTH    (`LDPC_ROW_DEG_MAX + 1)

`endif

// File: hdl/ldpc_msg_pkg.sv
// ------------------------------------------------
// message-level types of the min-sum decoder.
// node values, sums, magnitudes and the per-row
// result that the check-node unit hands to update.
// ------------------------------------------------

`include "ldpc_defines.svh"

package ldpc_msg_pkg;

  // ------------------------------------------------
  // scalar values
  // ------------------------------------------------

  // a check-node message or a restored variable value.
  typedef logic signed [`LDPC_NODE_W-1:0] node_t;

  // a variable-node sum, wider to hold the accumulation.
  typedef logic signed [`LDPC_SUM_W-1:0] node_sum_t;

  // magnitudes are symmetric-saturated, so the sign bit is dropped.
  typedef logic [`LDPC_NODE_W-2:0] mag_t;

  // position of a variable node inside its row.
  typedef logic [$clog2(`LDPC_ROW_DEG_MAX)-1:0] deg_idx_t;

  // ------------------------------------------------
  // row result
  // ------------------------------------------------

  // min1 and min2 are already normalised when this leaves min-sum.
  // sign_par is the xor of all signs in the row.
  typedef struct packed {
    mag_t     min1;
    mag_t     min2;
    deg_idx_t min1_idx;
    logic     sign_par;
  } row_result_t;

endpackage

// File: hdl/ldpc_stream_pkg.sv
// ------------------------------------------------
// stream framing of the row-update datapath.
// beat layouts at the input, after restore and at
// the output, with the column address type.
// ------------------------------------------------

`include "ldpc_defines.svh"

package ldpc_stream_pkg;

  import ldpc_msg_pkg::*;

  typedef logic [`LDPC_COL_W-1:0] col_addr_t;

  // one variable node of a row, sop and eop frame the row.
  typedef struct packed {
    node_sum_t sum;
    node_t     cnode;
    col_addr_t addr;
    logic      sop;
    logic      eop;
  } in_beat_t;

  // extrinsic value after the old message is taken out.
  typedef struct packed {
    node_t     vnode;
    col_addr_t addr;
    logic      sop;
    logic      eop;
  } rst_beat_t;

  // updated sum, new message and hard decision.
  typedef struct packed {
    node_sum_t sum;
    node_t     cnode;
    logic      hd;
    col_addr_t addr;
  } out_beat_t;

endpackage

// File: hdl/ldpc_vnode_restore.sv
// ------------------------------------------------
// extrinsic restore of the variable node.
// subtracts the old check message from the sum and
// saturates to message width over two cycles.
// ------------------------------------------------

`timescale 1ns/1ps

module ldpc_vnode_restore
  import ldpc_msg_pkg::*, ldpc_stream_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      ival,
  input  in_beat_t  ibeat,
  output logic      oval,
  output rst_beat_t obeat
);

  localparam int NODE_W = $bits(node_t);
  localparam int SUM_W  = $bits(node_sum_t);

  // symmetric limits, -128 is clipped as well as overflows.
  localparam logic signed [SUM_W:0] SAT_MAX = (SUM_W+1)'((1 << (NODE_W - 1)) - 1);
  localparam logic signed [SUM_W:0] SAT_MIN = -SAT_MAX;

  logic [1:0]            val;
  logic signed [SUM_W:0] sum_ext;
  logic signed [SUM_W:0] cnode_ext;
  logic signed [SUM_W:0] diff;
  col_addr_t             addr_s1;
  logic                  sop_s1;
  logic                  eop_s1;

  // one guard bit above the sum width keeps the difference exact.
  assign sum_ext   = ibeat.sum;
  assign cnode_ext = ibeat.cnode;

  // ------------------------------------------------
  // valid pipeline
  // ------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val <= '0;
    end else begin
      val <= {val[0], ival};
    end
  end

  assign oval = val[1];

  // ------------------------------------------------
  // data pipeline
  // ------------------------------------------------

  // stage one subtracts, stage two clips to the message range.
  always_ff @(posedge iclk) begin
    diff        <= sum_ext - cnode_ext;
    addr_s1     <= ibeat.addr;
    sop_s1      <= ibeat.sop;
    eop_s1      <= ibeat.eop;
    obeat.vnode <= saturate(diff);
    obeat.addr  <= addr_s1;
    obeat.sop   <= sop_s1;
    obeat.eop   <= eop_s1;
  end

  function automatic node_t saturate(input logic signed [SUM_W:0] dat);
    if (dat > SAT_MAX) begin
      return node_t'(SAT_MAX[NODE_W-1:0]);
    end else if (dat < SAT_MIN) begin
      return node_t'(SAT_MIN[NODE_W-1:0]);
    end
    return node_t'(dat[NODE_W-1:0]);
  endfunction

endmodule

// File: hdl/ldpc_row_fifo.sv
// ------------------------------------------------
// synchronous first-word fall-through FIFO.
// the payload type is a parameter, so one block buffers
// restored beats and another buffers row results.
// ------------------------------------------------

`timescale 1ns/1ps

module ldpc_row_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     iclk,
  input  logic     ireset,
  input  logic     ipush,
  input  payload_t idata,
  input  logic     ipop,
  output payload_t odata,
  output logic     oempty,
  output logic     ospace_ok
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;

  // the depth need not be a power of two, so pointers wrap explicitly.
  always_comb begin
    count_next = count;
    case ({ipush, ipop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      ospace_ok <= 1'b0;
    end else begin
      if (ipush) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (ipop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      // registered from the next count, so it tracks count without lag.
      ospace_ok <= (count_next <= CNT_W'(DEPTH - 3));
    end
  end

  always_ff @(posedge iclk) begin
    if (ipush) begin
      mem[wr_ptr] <= idata;
    end
  end

  assign odata  = mem[rd_ptr];
  assign oempty = (count == '0);

  // the producers have no back-pressure, their sizing must hold.
  a_no_overflow : assert property (@(posedge iclk) disable iff (ireset)
    ipush |-> (count != CNT_W'(DEPTH)))
    else $error("fifo: push while full");

  a_no_underflow : assert property (@(posedge iclk) disable iff (ireset)
    ipop |-> !oempty)
    else $error("fifo: pop while empty");

endmodule

// File: hdl/ldpc_cnode_min_sum.sv
// ------------------------------------------------
// min-sum check-node unit.
// tracks min1, min2, the min1 position and the sign
// parity over a row, then registers the normalised
// result on the cycle after the eop beat.
// ------------------------------------------------

`timescale 1ns/1ps

`include "ldpc_defines.svh"

module ldpc_cnode_min_sum
  import ldpc_msg_pkg::*, ldpc_stream_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  logic        ival,
  input  rst_beat_t   ibeat,
  output logic        oval,
  output row_result_t oresult
);

  localparam int NODE_W = $bits(node_t);

  mag_t     min1;
  mag_t     min2;
  deg_idx_t min1_idx;
  logic     sign_par;
  deg_idx_t pos;
  logic     row_open;

  mag_t     mag;
  logic     sgn;
  mag_t     cur_min1;
  mag_t     cur_min2;
  deg_idx_t cur_idx;
  logic     cur_par;
  deg_idx_t cur_pos;
  mag_t     nxt_min1;
  mag_t     nxt_min2;
  deg_idx_t nxt_idx;
  logic     nxt_par;

  // ------------------------------------------------
  // running search
  // ------------------------------------------------

  always_comb begin
    // zero counts as positive.
    sgn = ibeat.vnode[NODE_W-1];
    mag = sgn ? mag_t'(-ibeat.vnode) : mag_t'(ibeat.vnode);
    // a sop beat starts from a clean state instead of the stored one.
    cur_min1 = ibeat.sop ? '1 : min1;
    cur_min2 = ibeat.sop ? '1 : min2;
    cur_idx  = ibeat.sop ? '0 : min1_idx;
    cur_par  = ibeat.sop ? 1'b0 : sign_par;
    cur_pos  = ibeat.sop ? '0 : pos;
    nxt_min1 = cur_min1;
    nxt_min2 = cur_min2;
    nxt_idx  = cur_idx;
    nxt_par  = cur_par ^ sgn;
    // a tie with min1 lands in min2, which is what the update needs.
    if (mag < cur_min1) begin
      nxt_min2 = cur_min1;
      nxt_min1 = mag;
      nxt_idx  = cur_pos;
    end else if (mag < cur_min2) begin
      nxt_min2 = mag;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      pos      <= '0;
      row_open <= 1'b0;
      oval     <= 1'b0;
    end else begin
      oval <= ival & ibeat.eop;
      if (ival) begin
        pos      <= cur_pos + 1'b1;
        row_open <= !ibeat.eop;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (ival) begin
      min1     <= nxt_min1;
      min2     <= nxt_min2;
      min1_idx <= nxt_idx;
      sign_par <= nxt_par;
    end
    if (ival && ibeat.eop) begin
      oresult.min1     <= normalise(nxt_min1);
      oresult.min2     <= normalise(nxt_min2);
      oresult.min1_idx <= nxt_idx;
      oresult.sign_par <= nxt_par;
    end
  end

  // scale by NORM_FACTOR / 8, truncating toward zero.
  function automatic mag_t normalise(input mag_t m);
    logic [NODE_W+2:0] prod;
    prod = m * (NODE_W+3)'(`LDPC_NORM_FACTOR);
    return mag_t'(prod >> 3);
  endfunction

  // rows arrive back to back, so every beat after eop must open a row.
  a_sop_after_eop : assert property (@(posedge iclk) disable iff (ireset)
    ival |-> (ibeat.sop == !row_open))
    else $error("min-sum: sop does not follow eop");

endmodule

// File: hdl/ldpc_vnode_update.sv
// ------------------------------------------------
// variable-node update stage.
// pairs each buffered restored value with the row
// result, forms the new message, sum and hard
// decision, and holds them in an output register.
// ------------------------------------------------

`timescale 1ns/1ps

module ldpc_vnode_update
  import ldpc_msg_pkg::*, ldpc_stream_pkg::*;
(
  input  logic        iclk,
  input  logic        ireset,
  input  rst_beat_t   ibeat,
  input  logic        ibeat_empty,
  input  row_result_t iresult,
  input  logic        iresult_empty,
  output logic        obeat_pop,
  output logic        oresult_pop,
  output logic        oval,
  output out_beat_t   obeat,
  input  logic        iready
);

  localparam int NODE_W = $bits(node_t);
  localparam int SUM_W  = $bits(node_sum_t);

  deg_idx_t  pos;
  logic      load_ok;
  logic      fire;
  mag_t      new_mag;
  logic      new_sgn;
  node_t     mag_ext;
  node_t     new_msg;
  node_sum_t vnode_ext;
  node_sum_t msg_ext;
  node_sum_t new_sum;

  // ------------------------------------------------
  // handshake
  // ------------------------------------------------

  // the output register takes a new beat when empty or drained.
  assign load_ok = !oval || iready;

  // a beat can only leave once its row result exists.
  assign fire        = load_ok && !ibeat_empty && !iresult_empty;
  assign obeat_pop   = fire;
  assign oresult_pop = fire && ibeat.eop;

  // ------------------------------------------------
  // new message and sum
  // ------------------------------------------------

  always_comb begin
    // the min1 node gets min2, all others get min1.
    new_mag = (pos == iresult.min1_idx) ? iresult.min2 : iresult.min1;
    // own sign taken out of the parity, zero counts as positive.
    new_sgn = iresult.sign_par ^ ibeat.vnode[NODE_W-1];
    mag_ext = node_t'({1'b0, new_mag});
    new_msg = new_sgn ? -mag_ext : mag_ext;
    // both operands sign-extend to the full sum width.
    vnode_ext = ibeat.vnode;
    msg_ext   = new_msg;
    new_sum   = vnode_ext + msg_ext;
  end

  // position within the current row, restarted after eop.
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      pos  <= '0;
      oval <= 1'b0;
    end else begin
      if (fire) begin
        pos <= ibeat.eop ? '0 : pos + 1'b1;
      end
      if (load_ok) begin
        oval <= fire;
      end
    end
  end

  // payload stays put while out_ready is low.
  always_ff @(posedge iclk) begin
    if (fire) begin
      obeat.sum   <= new_sum;
      obeat.cnode <= new_msg;
      obeat.hd    <= new_sum[SUM_W-1];
      obeat.addr  <= ibeat.addr;
    end
  end

endmodule

// File: hdl/ldpc_row_update_top.sv
// ------------------------------------------------
// row-update datapath of a layered min-sum decoder.
// in_beat streams one row at a time under valid and
// ready, out_beat returns updated sums and messages
// in input order under its own valid and ready.
// ------------------------------------------------

`timescale 1ns/1ps

`include "ldpc_defines.svh"

module ldpc_row_update_top
  import ldpc_msg_pkg::*, ldpc_stream_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      in_valid,
  input  in_beat_t  in_beat,
  output logic      in_ready,
  output logic      out_valid,
  output out_beat_t out_beat,
  input  logic      out_ready
);

  logic        accept;
  logic        rst_val;
  rst_beat_t   rst_beat;
  rst_beat_t   buf_beat;
  logic        beat_empty;
  logic        beat_space_ok;
  logic        beat_pop;
  logic        res_val;
  row_result_t res_data;
  row_result_t buf_result;
  logic        res_empty;
  logic        res_pop;

  // three free entries cover the two beats still inside restore.
  assign in_ready = beat_space_ok;
  assign accept   = in_valid && in_ready;

  ldpc_vnode_restore u_restore (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (accept),
    .ibeat  (in_beat),
    .oval   (rst_val),
    .obeat  (rst_beat)
  );

  ldpc_row_fifo #(
    .payload_t (rst_beat_t),
    .DEPTH     (`LDPC_BEAT_DEPTH)
  ) u_beat_fifo (
    .iclk      (iclk),
    .ireset    (ireset),
    .ipush     (rst_val),
    .idata     (rst_beat),
    .ipop      (beat_pop),
    .odata     (buf_beat),
    .oempty    (beat_empty),
    .ospace_ok (beat_space_ok)
  );

  ldpc_cnode_min_sum u_min_sum (
    .iclk    (iclk),
    .ireset  (ireset),
    .ival    (rst_val),
    .ibeat   (rst_beat),
    .oval    (res_val),
    .oresult (res_data)
  );

  // each row leaves at least two beats behind, so this never fills.
  ldpc_row_fifo #(
    .payload_t (row_result_t),
    .DEPTH     (`LDPC_ROW_DEPTH)
  ) u_result_fifo (
    .iclk      (iclk),
    .ireset    (ireset),
    .ipush     (res_val),
    .idata     (res_data),
    .ipop      (res_pop),
    .odata     (buf_result),
    .oempty    (res_empty),
    .ospace_ok ()
  );

  ldpc_vnode_update u_update (
    .iclk          (iclk),
    .ireset        (ireset),
    .ibeat         (buf_beat),
    .ibeat_empty   (beat_empty),
    .iresult       (buf_result),
    .iresult_empty (res_empty),
    .obeat_pop     (beat_pop),
    .oresult_pop   (res_pop),
    .oval          (out_valid),
    .obeat         (out_beat),
    .iready        (out_ready)
  );

endmodule

// File: tests/ldpc_row_model.svh
// ------------------------------------------------
// reference model of the row update, included inside
// the testbench module. accepted beats collect per
// row, and on eop the expected output beats of the
// whole row are computed and queued in input order.
// ------------------------------------------------

  // largest message magnitude, the clip is symmetric around zero.
  localparam int NODE_LIM = (1 << (`LDPC_NODE_W - 1)) - 1;

  // beats of the row now being accepted.
  in_beat_t  row_buf[$];
  // expected output beats, oldest first.
  out_beat_t exp_q[$];

  // extrinsic value, the old message taken out of the sum and clipped.
  function automatic int model_restore(input in_beat_t b);
    int d;
    d = int'(b.sum) - int'(b.cnode);
    if (d > NODE_LIM) begin
      d = NODE_LIM;
    end else if (d < -NODE_LIM) begin
      d = -NODE_LIM;
    end
    return d;
  endfunction

  // magnitudes are never negative, so division truncates like a shift.
  function automatic int model_norm(input int m);
    return (m * `LDPC_NORM_FACTOR) / 8;
  endfunction

  function automatic void model_close_row();
    int        v[`LDPC_ROW_DEG_MAX];
    int        mag[`LDPC_ROW_DEG_MAX];
    int        deg;
    int        min1;
    int        min2;
    int        idx;
    int        m;
    int        msg;
    int        s;
    bit        par;
    out_beat_t ob;
    deg  = row_buf.size();
    min1 = NODE_LIM + 1;
    min2 = NODE_LIM + 1;
    idx  = 0;
    par  = 1'b0;
    // the earliest of equal smallest magnitudes owns the min1 position.
    for (int i = 0; i < deg; i++) begin
      v[i]   = model_restore(row_buf[i]);
      mag[i] = (v[i] < 0) ? -v[i] : v[i];
      par    = par ^ (v[i] < 0);
      if (mag[i] < min1) begin
        min1 = mag[i];
        idx  = i;
      end
    end
    // second minimum is the smallest over every other position.
    for (int i = 0; i < deg; i++) begin
      if (i != idx && mag[i] < min2) begin
        min2 = mag[i];
      end
    end
    for (int i = 0; i < deg; i++) begin
      m        = (i == idx) ? model_norm(min2) : model_norm(min1);
      msg      = (par ^ (v[i] < 0)) ? -m : m;
      s        = v[i] + msg;
      ob.sum   = node_sum_t'(s);
      ob.cnode = node_t'(msg);
      ob.hd    = (s < 0);
      ob.addr  = row_buf[i].addr;
      exp_q.push_back(ob);
    end
    row_buf.delete();
  endfunction

  function automatic void model_accept(input in_beat_t b);
    row_buf.push_back(b);
    if (b.eop) begin
      model_close_row();
    end
  endfunction

// File: tests/tb_ldpc_row_update.sv
// ------------------------------------------------
// testbench of the row-update datapath.
// drives random rows from an lfsr, checks every
// output beat against the included model and stalls
// the output with random gaps. prints one line per
// test and a closing line with the counts.
// ------------------------------------------------

`timescale 1ns/1ps

`include "ldpc_defines.svh"

module tb_ldpc_row_update
  import ldpc_msg_pkg::*, ldpc_stream_pkg::*;
();

  localparam int ROWS_SAT   = 8;
  localparam int ROWS_MIN   = 30;
  localparam int ROWS_SIGN  = 20;
  localparam int ROWS_ORDER = 40;
  localparam int ROWS_BP    = 30;
  localparam int TOTAL_ROWS = ROWS_SAT + ROWS_MIN + ROWS_SIGN + ROWS_ORDER + ROWS_BP;
  // eight cycles per beat are enough at an output rate of one in four.
  localparam int TIMEOUT_CYCLES = TOTAL_ROWS * `LDPC_ROW_DEG_MAX * 8 + 50;
  localparam int SUM_MAX  = (1 << (`LDPC_SUM_W - 1)) - 1;
  localparam int NODE_MIN = -(1 << (`LDPC_NODE_W - 1));

  logic      iclk;
  logic      ireset;
  logic      in_valid;
  in_beat_t  in_beat;
  logic      in_ready;
  logic      out_valid;
  out_beat_t out_beat;
  logic      out_ready = 1'b0;

  logic [15:0] stim_lfsr     = 16'd32867;
  logic [15:0] gap_lfsr      = 16'd32867;
  bit          bp_on         = 1'b0;
  bit          saw_ready_low = 1'b0;
  bit          stalled       = 1'b0;
  out_beat_t   held_beat;
  col_addr_t   addr_next     = '0;
  int          errors;
  int          checks;
  int          cycles;
  int          tests_run;
  int          beats_in;
  int          beats_out;
  int          rows_accepted;

  `include "ldpc_row_model.svh"

  ldpc_row_update_top uut (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

  initial iclk = 1'b0;
  always #5 iclk = ~iclk;

  // ------------------------------------------------
  // random bits
  // ------------------------------------------------

  // the polynomial is x^16 + x^14 + x^13 + x^11 + 1 and it steps once per bit taken.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  // the output sink is ready one cycle in four while back-pressure is on.
  always @(posedge iclk) begin
    if (bp_on) begin
      gap_lfsr = lfsr_next(lfsr_next(gap_lfsr));
      out_ready <= (gap_lfsr[1:0] == 2'b00);
    end else begin
      out_ready <= !ireset;
    end
  end

  // ------------------------------------------------
  // checking
  // ------------------------------------------------

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic compare_out();
    out_beat_t exp;
    beats_out++;
    if (exp_q.size() == 0) begin
      errors++;
      $display("at %0t ns an output beat came out with no beat expected", $time);
    end else begin
      exp = exp_q.pop_front();
      check_val("out_beat.sum", 64'(out_beat.sum), 64'(exp.sum));
      check_val("out_beat.cnode", 64'(out_beat.cnode), 64'(exp.cnode));
      check_val("out_beat.hd", 64'(out_beat.hd), 64'(exp.hd));
      check_val("out_beat.addr", 64'(out_beat.addr), 64'(exp.addr));
    end
  endtask

  // output side is checked before the input side queues new rows.
  always @(posedge iclk) begin
    if (!ireset) begin
      // a stalled beat must sit unchanged until it is taken.
      if (stalled) begin
        check_val("out_valid", 64'(out_valid), 64'(1'b1));
        check_val("out_beat", 64'(out_beat), 64'(held_beat));
      end
      stalled   = out_valid && !out_ready;
      held_beat = out_beat;
      if (rows_accepted == 0) begin
        check_val("out_valid", 64'(out_valid), 64'(1'b0));
      end
      if (out_valid && out_ready) begin
        compare_out();
      end
      if (in_valid && in_ready) begin
        beats_in++;
        if (in_beat.eop) begin
          rows_accepted++;
        end
        model_accept(in_beat);
      end
      if (in_valid && !in_ready && bp_on) begin
        saw_ready_low = 1'b1;
      end
    end
  end

  always @(posedge iclk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------

  // holds the beat until the cycle in which in_ready takes it.
  task automatic send_beat(input in_beat_t b);
    in_valid <= 1'b1;
    in_beat  <= b;
    @(posedge iclk);
    while (!in_ready) begin
      @(posedge iclk);
    end
  endtask

  // mode 0 hits the clip limits. mode 1 gives small values with ties
  // and zeros. mode 2 is fully random with mixed signs.
  task automatic send_row(input int mode);
    int          deg;
    logic [31:0] r;
    in_beat_t    b;
    deg = 2 + int'(rand_bits(4)) % (`LDPC_ROW_DEG_MAX - 1);
    for (int i = 0; i < deg; i++) begin
      b = '0;
      if (mode == 0) begin
        r = rand_bits(2);
        case (r[1:0])
          2'd0: begin
            b.sum   = node_sum_t'(SUM_MAX);
            b.cnode = node_t'(NODE_MIN);
          end
          2'd1: begin
            b.sum   = node_sum_t'(-SUM_MAX - 1);
            b.cnode = node_t'(NODE_LIM);
          end
          2'd2: begin
            b.sum   = node_sum_t'(rand_bits(`LDPC_SUM_W));
            b.cnode = node_t'(NODE_MIN);
          end
          default: begin
            b.sum   = node_sum_t'(rand_bits(`LDPC_SUM_W));
            b.cnode = node_t'(rand_bits(`LDPC_NODE_W));
          end
        endcase
      end else if (mode == 1) begin
        r       = rand_bits(6);
        b.sum   = node_sum_t'($signed(r[3:0]));
        b.cnode = node_t'($signed(r[5:4]));
      end else begin
        b.sum   = node_sum_t'(rand_bits(`LDPC_SUM_W));
        b.cnode = node_t'(rand_bits(`LDPC_NODE_W));
      end
      b.addr    = addr_next;
      b.sop     = (i == 0);
      b.eop     = (i == deg - 1);
      addr_next = addr_next + 1'b1;
      send_beat(b);
    end
  endtask

  // done once every queued beat has come out and the output is idle.
  task automatic wait_drain();
    do begin
      @(posedge iclk);
    end while (exp_q.size() != 0 || row_buf.size() != 0 || out_valid);
  endtask

  task automatic print_result(input string name, input int err0, input int nbeats);
    tests_run++;
    $display("test %0d %s: %s, %0d beats, %0d errors", tests_run, name,
             (errors == err0) ? "ok" : "mismatch", nbeats, errors - err0);
  endtask

  task automatic run_test(input string name, input int rows, input int mode,
                          input bit bp);
    int err0;
    int b0;
    err0  = errors;
    b0    = beats_in;
    bp_on <= bp;
    for (int r = 0; r < rows; r++) begin
      send_row(mode);
    end
    in_valid <= 1'b0;
    wait_drain();
    bp_on <= 1'b0;
    check_val("beat count", 64'(beats_out), 64'(beats_in));
    if (bp && !saw_ready_low) begin
      errors++;
      $display("in_ready never fell while the output was stalled");
    end
    print_result(name, err0, beats_in - b0);
  endtask

  // ------------------------------------------------
  // test sequence
  // ------------------------------------------------

  initial begin
    int err0;
    ireset   = 1'b0;
    in_valid = 1'b0;
    in_beat  = '0;
    err0     = errors;
    // reset rises just after time zero and is held over two clock edges.
    #1 ireset = 1'b1;
    repeat (2) begin
      @(posedge iclk);
      check_val("in_ready", 64'(in_ready), 64'(1'b0));
      check_val("out_valid", 64'(out_valid), 64'(1'b0));
    end
    ireset <= 1'b0;
    repeat (3) @(posedge iclk);
    check_val("in_ready", 64'(in_ready), 64'(1'b1));
    print_result("reset state", err0, 0);

    run_test("restore saturation", ROWS_SAT, 0, 1'b0);
    run_test("min-sum selection", ROWS_MIN, 1, 1'b0);
    run_test("sign rule and hard decision", ROWS_SIGN, 2, 1'b0);
    run_test("order and addresses", ROWS_ORDER, 2, 1'b0);
    run_test("back-pressure", ROWS_BP, 2, 1'b1);

    $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+hdl
+incdir+tests
hdl/ldpc_msg_pkg.sv
hdl/ldpc_stream_pkg.sv
hdl/ldpc_vnode_restore.sv
hdl/ldpc_row_fifo.sv
hdl/ldpc_cnode_min_sum.sv
hdl/ldpc_vnode_update.sv
hdl/ldpc_row_update_top.sv
tests/tb_ldpc_row_update.sv

// File: Makefile
# Verilator build and run of the row-update testbench.

SRCS := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv tests/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_ldpc_row_update: compile.f $(SRCS)
	verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
		-f compile.f --top-module tb_ldpc_row_update

run: obj_dir/Vtb_ldpc_row_update
	./obj_dir/Vtb_ldpc_row_update > sim.log || true
	@cat sim.log
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
